/* isa_pkg.sv */
package isa_pkg;

	// operand and result width
	localparam int DATA_W = 32;

	typedef logic [DATA_W-1:0] data_t;

	typedef enum logic [1:0] {
		OP_ADD = 2'd0,
		OP_SUB = 2'd1,
		OP_XOR = 2'd2,
		OP_MUL = 2'd3
	} op_t;

	// cycles from dispatch to the CDB
	localparam int ALU_LATENCY = 1;

	// also the length of the reservation register
	localparam int MUL_LATENCY = 3;

endpackage

/* rob_pkg.sv */
package rob_pkg;
	import isa_pkg::*;

	// tags are sized for the largest ROB
	localparam int ROB_DEPTH_MAX = 16;
	localparam int TAG_W = $clog2(ROB_DEPTH_MAX);

	typedef logic [TAG_W-1:0] tag_t;

	typedef struct packed {
		logic  valid;
		tag_t  tag;
		data_t data;
	} cdb_t;

	// low partial product and tag inside the multiplier
	typedef struct packed {
		tag_t  tag;
		data_t prod;
	} mul_stage_t;

endpackage

/* issue_if.sv */
`timescale 1ns/1ps

interface issue_if import isa_pkg::*, rob_pkg::*; ();

	logic  valid;
	op_t   op;
	data_t a;
	data_t b;
	tag_t  tag;

	// issue queue
	modport source (
		output valid,
		output op,
		output a,
		output b
	);

	// reorder buffer hands out the tag
	modport alloc (
		input  valid,
		output tag
	);

	modport sink (
		input valid,
		input op,
		input a,
		input b,
		input tag
	);

endinterface

/* issue_queue.sv */
`timescale 1ns/1ps

module issue_queue import isa_pkg::*; #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic    clk,
	input  logic    arst_n,
	input  logic    in_valid,
	input  op_t     in_op,
	input  data_t   in_a,
	input  data_t   in_b,
	output logic    in_credit,
	input  logic    slot_free_alu,
	input  logic    slot_free_mul,
	input  logic    rob_space,
	issue_if.source dispatch
);
	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	op_t              op_mem[QUEUE_DEPTH];
	data_t            a_mem[QUEUE_DEPTH];
	data_t            b_mem[QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             slot_free;
	logic             pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// head leaves once its result slot and a ROB entry are free
	assign slot_free = (op_mem[rd_ptr] == OP_MUL) ? slot_free_mul : slot_free_alu;
	assign pop       = (count != '0) && slot_free && rob_space;

	assign dispatch.valid = pop;
	assign dispatch.op    = op_mem[rd_ptr];
	assign dispatch.a     = a_mem[rd_ptr];
	assign dispatch.b     = b_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (in_valid) begin
			op_mem[wr_ptr] <= in_op;
			a_mem[wr_ptr]  <= in_a;
			b_mem[wr_ptr]  <= in_b;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			in_credit <= 1'b0;
		end else begin
			if (in_valid) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count     <= count + CNT_W'(in_valid) - CNT_W'(pop);
			// one credit back per entry gone
			in_credit <= pop;
		end
	end

	// sender must never push without a credit
	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		in_valid |-> count != CNT_W'(QUEUE_DEPTH));

endmodule

/* delay_pipe.sv */
`timescale 1ns/1ps

module delay_pipe #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 1
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);
	logic     valid_q[DEPTH];
	payload_t data_q[DEPTH];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				valid_q[i] <= 1'b0;
			end
		end else begin
			valid_q[0] <= in_valid;
			for (int i = 1; i < DEPTH; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		data_q[0] <= in_data;
		for (int i = 1; i < DEPTH; i++) begin
			data_q[i] <= data_q[i-1];
		end
	end

	assign out_valid = valid_q[DEPTH-1];
	assign out_data  = data_q[DEPTH-1];

endmodule

/* alu_unit.sv */
`timescale 1ns/1ps

module alu_unit import isa_pkg::*, rob_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	issue_if.sink dispatch,
	output cdb_t  result
);
	data_t alu_out;
	logic  res_valid;
	tag_t  res_tag;
	data_t res_data;

	always_comb begin
		case (dispatch.op)
			OP_SUB:  alu_out = dispatch.a - dispatch.b;
			OP_XOR:  alu_out = dispatch.a ^ dispatch.b;
			default: alu_out = dispatch.a + dispatch.b;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= dispatch.valid && (dispatch.op != OP_MUL);
		end
	end

	// payload only follows a real dispatch
	always_ff @(posedge clk) begin
		if (dispatch.valid) begin
			res_tag  <= dispatch.tag;
			res_data <= alu_out;
		end
	end

	assign result = '{valid: res_valid, tag: res_tag, data: res_data};

endmodule

/* mul_unit.sv */
`timescale 1ns/1ps

module mul_unit import isa_pkg::*, rob_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	issue_if.sink dispatch,
	output cdb_t  result
);
	localparam int PIPE_DEPTH = MUL_LATENCY - 1;

	logic       start;
	mul_stage_t low_in;
	mul_stage_t low_out;
	logic       low_valid;
	data_t      cross_in;
	data_t      cross_out;
	logic       cross_valid;
	logic       res_valid;
	tag_t       res_tag;
	data_t      res_data;

	assign start = dispatch.valid && (dispatch.op == OP_MUL);

	// a*b mod 2^32 = a*b[15:0] + (a[15:0]*b[31:16] << 16)
	assign low_in   = '{tag: dispatch.tag, prod: dispatch.a * {16'b0, dispatch.b[15:0]}};
	assign cross_in = {dispatch.a[15:0] * dispatch.b[31:16], 16'b0};

	delay_pipe #(.payload_t(mul_stage_t), .DEPTH(PIPE_DEPTH)) u_low_pipe (
		.clk, .arst_n,
		.in_valid(start), .in_data(low_in),
		.out_valid(low_valid), .out_data(low_out)
	);

	delay_pipe #(.payload_t(data_t), .DEPTH(PIPE_DEPTH)) u_cross_pipe (
		.clk, .arst_n,
		.in_valid(start), .in_data(cross_in),
		.out_valid(cross_valid), .out_data(cross_out)
	);

	// final stage sums the partial products
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= low_valid && cross_valid;
		end
	end

	always_ff @(posedge clk) begin
		res_tag  <= low_out.tag;
		res_data <= low_out.prod + cross_out;
	end

	assign result = '{valid: res_valid, tag: res_tag, data: res_data};

endmodule

/* cdb_scheduler.sv */
`timescale 1ns/1ps

module cdb_scheduler import isa_pkg::*, rob_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	issue_if.sink dispatch,
	input  cdb_t  alu_result,
	input  cdb_t  mul_result,
	output logic  slot_free_alu,
	output logic  slot_free_mul,
	output cdb_t  cdb
);
	//////////////////////////////////////////////////
	// reservations
	//////////////////////////////////////////////////

	// bit i set means the CDB is taken i+1 cycles from now
	logic [MUL_LATENCY-1:0] rsv;
	logic [MUL_LATENCY-1:0] booked;

	assign slot_free_alu = !rsv[ALU_LATENCY-1];
	assign slot_free_mul = !rsv[MUL_LATENCY-1];

	always_comb begin
		booked = rsv;
		if (dispatch.valid) begin
			if (dispatch.op == OP_MUL) begin
				booked[MUL_LATENCY-1] = 1'b1;
			end else begin
				booked[ALU_LATENCY-1] = 1'b1;
			end
		end
	end

	// shift toward the current cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rsv <= '0;
		end else begin
			rsv <= booked >> 1;
		end
	end

	//////////////////////////////////////////////////
	// merge
	//////////////////////////////////////////////////

	assign cdb = alu_result.valid ? alu_result : mul_result;

	a_one_driver: assert property (@(posedge clk) disable iff (!arst_n)
		!(alu_result.valid && mul_result.valid));

	// a slot held for the multiplier gets its result
	a_slot_filled: assert property (@(posedge clk) disable iff (!arst_n)
		rsv[0] |=> mul_result.valid);

endmodule

/* reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer import isa_pkg::*, rob_pkg::*; #(
	parameter int ROB_DEPTH = 4
) (
	input  logic   clk,
	input  logic   arst_n,
	issue_if.alloc dispatch,
	input  cdb_t   cdb,
	output logic   rob_space,
	output logic   commit_valid,
	output tag_t   commit_tag,
	output data_t  commit_data
);
	localparam int PTR_W = $clog2(ROB_DEPTH);
	localparam int CNT_W = $clog2(ROB_DEPTH + 1);

	logic [ROB_DEPTH-1:0] busy;
	logic [ROB_DEPTH-1:0] done;
	data_t                result_mem[ROB_DEPTH];
	logic [PTR_W-1:0]     head;
	logic [PTR_W-1:0]     tail;
	logic [CNT_W-1:0]     count;
	logic [PTR_W-1:0]     wb_idx;

	//////////////////////////////////////////////////
	// allocation
	//////////////////////////////////////////////////

	assign dispatch.tag = tag_t'(tail);
	assign rob_space    = count != CNT_W'(ROB_DEPTH);
	assign wb_idx       = cdb.tag[PTR_W-1:0];

	//////////////////////////////////////////////////
	// commit
	//////////////////////////////////////////////////

	// done is only ever set on a busy entry
	assign commit_valid = done[head];
	assign commit_tag   = tag_t'(head);
	assign commit_data  = result_mem[head];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy  <= '0;
			done  <= '0;
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (dispatch.valid) begin
				busy[tail] <= 1'b1;
				tail       <= tail + 1'b1;
			end
			if (cdb.valid) begin
				done[wb_idx] <= 1'b1;
			end
			if (commit_valid) begin
				busy[head] <= 1'b0;
				done[head] <= 1'b0;
				head       <= head + 1'b1;
			end
			count <= count + CNT_W'(dispatch.valid) - CNT_W'(commit_valid);
		end
	end

	// result capture from the CDB
	always_ff @(posedge clk) begin
		if (cdb.valid) begin
			result_mem[wb_idx] <= cdb.data;
		end
	end

	// each tag comes back once, and only while allocated
	a_cdb_write: assert property (@(posedge clk) disable iff (!arst_n)
		cdb.valid |-> (int'(cdb.tag) < ROB_DEPTH) && busy[wb_idx] && !done[wb_idx]);

endmodule

/* exec_core.sv */
`timescale 1ns/1ps

module exec_core import isa_pkg::*, rob_pkg::*; #(
	parameter int QUEUE_DEPTH = 4,
	parameter int ROB_DEPTH   = 4
) (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  in_valid,
	input  op_t   in_op,
	input  data_t in_a,
	input  data_t in_b,
	output logic  in_credit,
	output logic  commit_valid,
	output tag_t  commit_tag,
	output data_t commit_data
);
	logic slot_free_alu;
	logic slot_free_mul;
	logic rob_space;
	cdb_t alu_result;
	cdb_t mul_result;
	cdb_t cdb;

	issue_if dispatch_bus();

	//////////////////////////////////////////////////
	// issue
	//////////////////////////////////////////////////

	issue_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_issue_queue (
		.clk, .arst_n,
		.in_valid, .in_op, .in_a, .in_b,
		.in_credit,
		.slot_free_alu, .slot_free_mul, .rob_space,
		.dispatch(dispatch_bus.source)
	);

	//////////////////////////////////////////////////
	// units
	//////////////////////////////////////////////////

	alu_unit u_alu_unit (
		.clk, .arst_n,
		.dispatch(dispatch_bus.sink),
		.result(alu_result)
	);

	mul_unit u_mul_unit (
		.clk, .arst_n,
		.dispatch(dispatch_bus.sink),
		.result(mul_result)
	);

	//////////////////////////////////////////////////
	// cdb and commit
	//////////////////////////////////////////////////

	cdb_scheduler u_cdb_scheduler (
		.clk, .arst_n,
		.dispatch(dispatch_bus.sink),
		.alu_result, .mul_result,
		.slot_free_alu, .slot_free_mul,
		.cdb
	);

	reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_reorder_buffer (
		.clk, .arst_n,
		.dispatch(dispatch_bus.alloc),
		.cdb,
		.rob_space,
		.commit_valid, .commit_tag, .commit_data
	);

endmodule

/* tb_exec_core.sv */
`timescale 1ns/1ps

module tb_exec_core import isa_pkg::*, rob_pkg::*; ();

	localparam int QUEUE_DEPTH = 4;
	localparam int ROB_DEPTH   = 4;
	localparam int N_ROWS      = 64;
	localparam int N_FIXED     = 20;
	localparam int CYCLE_LIMIT = 40 * N_ROWS + 200;

	logic  clk;
	logic  arst_n;
	logic  in_valid;
	op_t   in_op;
	data_t in_a;
	data_t in_b;
	logic  in_credit;
	logic  commit_valid;
	tag_t  commit_tag;
	data_t commit_data;

	// stimulus table
	op_t   tab_op[N_ROWS];
	data_t tab_a[N_ROWS];
	data_t tab_b[N_ROWS];
	logic  tab_drain[N_ROWS];

	data_t       exp_q[$];
	int          exp_tag;
	int          sent;
	int          credit_pulses;
	int          commits;
	int          cycles;
	logic [31:0] seed;

	exec_core #(.QUEUE_DEPTH(QUEUE_DEPTH), .ROB_DEPTH(ROB_DEPTH)) u_dut (
		.clk, .arst_n,
		.in_valid, .in_op, .in_a, .in_b,
		.in_credit,
		.commit_valid, .commit_tag, .commit_data
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// expected result from the op rules
	function automatic data_t ref_result(input op_t op, input data_t a, input data_t b);
		logic [63:0] prod;
		prod = 64'(a) * 64'(b);
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_XOR:  return a ^ b;
			default: return prod[31:0];
		endcase
	endfunction

	function automatic int credits_held();
		return QUEUE_DEPTH - sent + credit_pulses;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping on first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
			fail_run("a checked value did not match its expected value");
		end
	endtask

	task automatic set_row(input int idx, input op_t op, input data_t a, input data_t b,
		input logic drain);
		tab_op[idx]    = op;
		tab_a[idx]     = a;
		tab_b[idx]     = b;
		tab_drain[idx] = drain;
	endtask

	// advance one falling edge and check credits and commits
	task automatic step();
		@(negedge clk);
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			fail_run("timeout: the run did not finish within the cycle limit");
		end
		if (in_credit) begin
			credit_pulses++;
			if (credits_held() > QUEUE_DEPTH) begin
				fail_run("more credits came back than operations were sent");
			end
		end
		if (commit_valid) begin
			if (exp_q.size() == 0) begin
				fail_run("commit seen with no operation outstanding");
			end else begin
				check_value("commit_data", commit_data, exp_q.pop_front());
				check_value("commit_tag", 32'(commit_tag), 32'(exp_tag));
				exp_tag = (exp_tag + 1) % ROB_DEPTH;
				commits++;
			end
		end
	endtask

	task automatic build_table();
		// alu only with wrap-around
		set_row(0, OP_ADD, 32'd5, 32'd7, 1'b1);
		set_row(1, OP_SUB, 32'd3, 32'd10, 1'b0);
		set_row(2, OP_XOR, 32'hffff_0000, 32'h0f0f_0f0f, 1'b0);
		set_row(3, OP_ADD, 32'hffff_ffff, 32'd2, 1'b0);
		set_row(4, OP_SUB, 32'h8000_0000, 32'd1, 1'b0);
		// back-to-back multiplications
		set_row(5, OP_MUL, 32'd6, 32'd7, 1'b1);
		set_row(6, OP_MUL, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
		set_row(7, OP_MUL, 32'h1234_5678, 32'h9abc_def0, 1'b0);
		set_row(8, OP_MUL, 32'h0001_0000, 32'h0001_0000, 1'b0);
		// short ops right behind long ones
		set_row(9, OP_MUL, 32'd7, 32'hffff_fffd, 1'b1);
		set_row(10, OP_ADD, 32'd1, 32'd1, 1'b0);
		set_row(11, OP_MUL, 32'h0001_0003, 32'h0002_0005, 1'b0);
		set_row(12, OP_XOR, 32'ha5a5_a5a5, 32'h5a5a_5a5a, 1'b0);
		set_row(13, OP_SUB, 32'd0, 32'd1, 1'b0);
		set_row(14, OP_MUL, 32'd3, 32'd3, 1'b0);
		set_row(15, OP_ADD, 32'd100, 32'd200, 1'b0);
		// burst of QUEUE_DEPTH from a full set of credits
		set_row(16, OP_MUL, 32'hdead_beef, 32'd16, 1'b1);
		set_row(17, OP_ADD, 32'h7fff_ffff, 32'd1, 1'b0);
		set_row(18, OP_MUL, 32'hcafe_0001, 32'h0000_ffff, 1'b0);
		set_row(19, OP_XOR, 32'h0000_0000, 32'hffff_ffff, 1'b0);
		// random stream whose first row waits for the burst to drain
		for (int i = N_FIXED; i < N_ROWS; i++) begin
			seed         = lcg_next(seed);
			tab_op[i]    = op_t'(seed[31:30]);
			seed         = lcg_next(seed);
			tab_a[i]     = seed;
			seed         = lcg_next(seed);
			tab_b[i]     = seed;
			tab_drain[i] = (i == N_FIXED);
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		arst_n        = 1'b0;
		in_valid      = 1'b0;
		in_op         = OP_ADD;
		in_a          = '0;
		in_b          = '0;
		exp_tag       = 0;
		sent          = 0;
		credit_pulses = 0;
		commits       = 0;
		cycles        = 0;
		seed          = 32'h7cbf_ac0e;
		build_table();

		repeat (16) @(negedge clk);
		arst_n = 1'b1;

		// quiet outputs before anything is sent
		repeat (4) begin
			step();
			check_value("commit_valid", 32'(commit_valid), 32'd0);
			check_value("in_credit", 32'(in_credit), 32'd0);
		end

		for (int i = 0; i < N_ROWS; i++) begin
			if (tab_drain[i]) begin
				// every committed op has left the queue and returned its credit
				while (commits != sent) begin
					step();
				end
				check_value("credit_pulses", 32'(credit_pulses), 32'(sent));
			end
			while (credits_held() == 0) begin
				step();
			end
			in_valid = 1'b1;
			in_op    = tab_op[i];
			in_a     = tab_a[i];
			in_b     = tab_b[i];
			sent++;
			exp_q.push_back(ref_result(tab_op[i], tab_a[i], tab_b[i]));
			step();
			in_valid = 1'b0;
		end

		while (commits != N_ROWS) begin
			step();
		end
		// a stray commit here would find an empty queue
		repeat (10) step();

		check_value("credit_pulses", 32'(credit_pulses), 32'(sent));
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* build.f */
isa_pkg.sv
rob_pkg.sv
issue_if.sv
issue_queue.sv
delay_pipe.sv
alu_unit.sv
mul_unit.sv
cdb_scheduler.sv
reorder_buffer.sv
exec_core.sv
tb_exec_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_exec_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG) || true
	@grep -q "$(PASS_MSG)" $(LOG) && echo "test: passed" || (echo "test: failed" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
